// File: list.f
hdl/cartridge_pkg.sv
hdl/slot_bridge.sv
hdl/vdp_port.sv
hdl/vram_array.sv
hdl/activity_monitor.sv
hdl/led_serializer.sv
hdl/vdp_cartridge_top.sv
verif/tb_vdp_cartridge.sv

// File: verif/cartridge_tests.txt
# columns: test name, operation, slot I/O address (hex), data or expected byte (hex)
# write/read are slot accesses, intr/level/quiet watch slot_intr, float reads an open port
clr_a_lo write 99 34
clr_a_hi write 99 12
clr_a_rd read 98 00
clr_b_lo write 99 5c
clr_b_hi write 99 2a
clr_b_rd0 read 98 00
clr_b_rd1 read 98 00
wr_lo write 99 fe
wr_hi write 99 7f
wr_d0 write 98 a5
wr_d1 write 98 3c
wr_d2 write 98 5a
wr_d3 write 98 c3
rd_lo write 99 fe
rd_hi write 99 3f
rd_d0 read 98 a5
rd_d1 read 98 3c
rd_wrap0 read 98 5a
rd_wrap1 read 98 c3
ie_val write 99 20
ie_reg write 99 81
frame_wait intr 00 00
status_set read 99 80
intr_clear level 00 00
status_clr read 99 00
ie_off_val write 99 00
ie_off_reg write 99 81
intr_quiet quiet 00 00
flag_again read 99 80
undecoded float 40 ff
rand_bursts random 00 06

// File: verif/tb_vdp_cartridge.sv
// testbench for the video-processor cartridge top level
// plays slot accesses from verif/cartridge_tests.txt, keeps a VRAM, port and event model,
// decodes the one-wire LED line and checks the last frame against the event counts
`timescale 1ns/100ps

module tb_vdp_cartridge import cartridge_pkg::*; ();

	logic		clk85m;
	logic		rst;
	logic		slot_iorq_n;
	logic		slot_rd_n;
	logic		slot_wr_n;
	logic [7:0]	slot_a;
	wire  [7:0]	slot_d;
	logic		slot_wait;
	logic		slot_intr;
	logic		slot_data_dir;
	logic		ws2812_led;
	logic		d_drive;			// host drives slot_d
	logic [7:0]	d_out;

	integer		seed;
	integer		checks;
	integer		errors;
	integer		timeouts;
	logic		abort;				// a wait timed out, stop the run

	// model state
	logic [7:0]	vram_m [0:(1 << vram_addr_w)-1];
	logic [vram_addr_w-1:0]	ptr_m;
	logic [7:0]	ahead_m;			// read-ahead byte
	logic [7:0]	ctrl_low_m;
	logic		ctrl_second_m;
	integer		reg_writes;
	integer		vram_writes;
	integer		status_reads;

	// LED decoder state
	integer		hi_cnt;
	integer		lo_cnt;
	integer		bit_cnt;
	integer		frames;
	logic [led_bits-1:0]	frame_bits;
	logic [led_bits-1:0]	last_frame;

	assign slot_d = d_drive ? d_out : 8'hzz;
	assign (weak0, weak1) slot_d = 8'hff;	// slot pull-up

	vdp_cartridge_top dut_i (.*);

	initial begin
		clk85m = 1'b0;
		forever #20 clk85m = ~clk85m;	// 25 MHz stand-in, period 40 ns
	end

	task automatic next_cycle();
		@(posedge clk85m);
		#1;						// drive and sample just after the edge
	endtask

	// ------------------------------
	// model of the port logic
	// ------------------------------
	task automatic model_write(input logic port, input logic [7:0] d);
		if (port == port_data) begin
			vram_m[ptr_m] = d;
			ptr_m = ptr_m + 1'b1;		// wraps at 14 bits
			vram_writes++;
		end else if (!ctrl_second_m) begin
			ctrl_low_m = d;
			ctrl_second_m = 1'b1;
		end else begin
			ctrl_second_m = 1'b0;
			if (d[7]) begin
				reg_writes++;
			end else begin
				ptr_m = {d[5:0], ctrl_low_m};
				if (!d[6]) begin		// read address, prefetch
					ahead_m = vram_m[ptr_m];
					ptr_m = ptr_m + 1'b1;
				end
			end
		end
	endtask

	task automatic model_read(input logic port, output logic [7:0] exp_d);
		exp_d = 8'h00;
		if (port == port_data) begin
			exp_d = ahead_m;
			ahead_m = vram_m[ptr_m];
			ptr_m = ptr_m + 1'b1;
		end else begin
			ctrl_second_m = 1'b0;		// status read resets the byte latch
			status_reads++;
		end
	endtask

	// ------------------------------
	// slot bus driver
	// ------------------------------
	task automatic slot_access(input logic is_read, input logic [7:0] a,
			input logic [7:0] wd, output logic [7:0] rd);
		integer n;
		slot_a = a;
		d_out = wd;
		d_drive = ~is_read;
		slot_iorq_n = 1'b0;
		slot_rd_n = ~is_read;
		slot_wr_n = is_read;
		repeat (4) next_cycle();		// bridge raises wait 3 cycles after the strobe
		n = 0;
		while (slot_wait !== 1'b0 && n < 64) begin
			next_cycle();
			n++;
		end
		if (slot_wait !== 1'b0) begin
			timeouts++;
			abort = 1'b1;
			$display("timeout: slot_wait stayed high on port %02h", a);
		end
		rd = slot_d;
		slot_iorq_n = 1'b1;
		slot_rd_n = 1'b1;
		slot_wr_n = 1'b1;
		d_drive = 1'b0;
		n = 0;
		while (slot_data_dir !== 1'b0 && n < 16) begin	// bus turned back
			next_cycle();
			n++;
		end
		if (slot_data_dir !== 1'b0) begin
			timeouts++;
			abort = 1'b1;
			$display("timeout: slot_data_dir stayed high after port %02h", a);
		end
		repeat (4) next_cycle();		// idle gap between host cycles
	endtask

	task automatic host_write(input logic [7:0] a, input logic [7:0] wd);
		logic [7:0] unused;
		slot_access(1'b0, a, wd, unused);
		if (a[7:1] == io_base[7:1])
			model_write(a[0], wd);
	endtask

	task automatic host_read(input logic [7:0] a, output logic [7:0] act,
			output logic [7:0] exp_d);
		slot_access(1'b1, a, 8'h00, act);
		exp_d = 8'h00;
		if (a[7:1] == io_base[7:1])
			model_read(a[0], exp_d);
	endtask

	task automatic set_vram_address(input logic [vram_addr_w-1:0] a, input logic is_write);
		host_write({io_base[7:1], port_ctrl}, a[7:0]);
		host_write({io_base[7:1], port_ctrl}, {1'b0, is_write, a[13:8]});
	endtask

	// ------------------------------
	// special operations
	// ------------------------------
	task automatic wait_intr(input logic [127:0] name);
		integer n;
		n = 0;
		while (slot_intr !== 1'b1 && n < frame_cycles + 1000) begin
			next_cycle();
			n++;
		end
		if (slot_intr !== 1'b1) begin
			timeouts++;
			abort = 1'b1;
			$display("timeout: %0s saw no interrupt within a frame", name);
		end
	endtask

	task automatic watch_quiet(input logic [127:0] name);
		integer n;
		logic seen;
		seen = 1'b0;
		for (n = 0; n < frame_cycles + 1000 && !seen; n++) begin	// spans a frame tick
			next_cycle();
			seen = (slot_intr !== 1'b0);
		end
		checks++;
		if (seen) begin
			errors++;
			$display("[ERROR] %0s: expected slot_intr 0, actual %b", name, slot_intr);
		end
	endtask

	task automatic float_read(input logic [127:0] name, input logic [7:0] a,
			input logic [7:0] exp_d);
		integer n;
		logic seen_wait;
		logic seen_dir;
		logic [7:0] act;
		seen_wait = 1'b0;
		seen_dir = 1'b0;
		slot_a = a;
		slot_iorq_n = 1'b0;
		slot_rd_n = 1'b0;
		for (n = 0; n < 8; n++) begin
			next_cycle();
			seen_wait = seen_wait | (slot_wait !== 1'b0);
			seen_dir = seen_dir | (slot_data_dir !== 1'b0);
		end
		act = slot_d;				// only the pull-up drives it
		slot_iorq_n = 1'b1;
		slot_rd_n = 1'b1;
		repeat (4) next_cycle();
		checks += 3;
		if (seen_wait) begin
			errors++;
			$display("[ERROR] %0s: expected slot_wait 0, actual 1", name);
		end
		if (seen_dir) begin
			errors++;
			$display("[ERROR] %0s: expected slot_data_dir 0, actual 1", name);
		end
		if (act !== exp_d) begin
			errors++;
			$display("[ERROR] %0s: expected %02h, actual %02h", name, exp_d, act);
		end
	endtask

	task automatic random_bursts(input logic [127:0] name, input integer bursts);
		logic [vram_addr_w-1:0] start [0:15];
		integer len [0:15];
		integer nb;
		integer b;
		integer i;
		logic [7:0] act;
		logic [7:0] exp_d;
		nb = (bursts > 16) ? 16 : bursts;
		for (b = 0; b < nb && !abort; b++) begin	// write phase
			start[b] = vram_addr_w'($random(seed));
			len[b] = 1 + ($random(seed) & 7);
			set_vram_address(start[b], 1'b1);
			for (i = 0; i < len[b]; i++)
				host_write({io_base[7:1], port_data}, 8'($random(seed)));
		end
		for (b = 0; b < nb && !abort; b++) begin	// read back
			set_vram_address(start[b], 1'b0);
			for (i = 0; i < len[b] && !abort; i++) begin
				host_read({io_base[7:1], port_data}, act, exp_d);
				checks++;
				if (act !== exp_d) begin
					errors++;
					$display("[ERROR] %0s: expected %02h, actual %02h (burst %0d byte %0d)",
						name, exp_d, act, b, i);
				end
			end
		end
	endtask

	// ------------------------------
	// test file lines
	// ------------------------------
	task automatic run_line(input logic [8*80-1:0] line);
		logic [127:0] name;
		logic [63:0] op;
		logic [7:0] a;
		logic [7:0] d;
		logic [7:0] act;
		logic [7:0] exp_d;
		integer cnt;
		name = '0;
		op = '0;
		cnt = $sscanf(line, "%s %s %h %h", name, op, a, d);
		if (cnt < 1 || name == "#") begin
			return;					// blank or comment
		end
		if (cnt != 4) begin
			errors++;
			$display("malformed test line for %0s", name);
		end else if (op == "write") begin
			host_write(a, d);
		end else if (op == "read") begin
			host_read(a, act, exp_d);
			checks++;
			if (act !== d) begin
				errors++;
				$display("[ERROR] %0s: expected %02h, actual %02h", name, d, act);
			end
		end else if (op == "intr") begin
			wait_intr(name);
		end else if (op == "level") begin
			checks++;
			if (slot_intr !== d[0]) begin
				errors++;
				$display("[ERROR] %0s: expected %b, actual %b", name, d[0], slot_intr);
			end
		end else if (op == "quiet") begin
			watch_quiet(name);
		end else if (op == "float") begin
			float_read(name, a, d);
		end else if (op == "random") begin
			random_bursts(name, d);
		end else begin
			errors++;
			$display("unknown operation %0s in test %0s", op, name);
		end
	endtask

	// ------------------------------
	// LED line decoder
	// ------------------------------
	always @(posedge clk85m) begin
		if (rst) begin
			hi_cnt = 0;
			lo_cnt = 0;
			bit_cnt = 0;
		end else if (ws2812_led === 1'b1) begin
			hi_cnt++;
			lo_cnt = 0;
		end else begin
			if (hi_cnt > 0) begin				// falling edge ends a symbol
				frame_bits = {frame_bits[led_bits-2:0], hi_cnt > (led_t0h + led_t1h) / 2};
				bit_cnt++;
				hi_cnt = 0;
			end
			lo_cnt++;
			if (lo_cnt == 2 * led_tbit && bit_cnt != 0) begin	// longer than any bit low
				if (bit_cnt == led_bits) begin
					last_frame = frame_bits;
					frames++;
				end else begin
					errors++;
					$display("LED frame ended after %0d bits instead of %0d", bit_cnt, led_bits);
				end
				bit_cnt = 0;
			end
		end
	end

	task automatic check_led();
		integer n;
		integer low_run;
		n = 0;
		low_run = 0;
		while (low_run <= led_treset + led_tbit && n < 8 * (led_bits * led_tbit + led_treset)) begin
			next_cycle();
			n++;
			low_run = (ws2812_led === 1'b0) ? low_run + 1 : 0;
		end
		if (low_run <= led_treset + led_tbit) begin
			timeouts++;
			abort = 1'b1;
			$display("timeout: LED line never settled after the last frame");
		end else if (frames == 0) begin
			errors++;
			$display("no complete LED frame was decoded");
		end else begin
			checks += 3;
			if (last_frame[23:16] !== vram_writes[7:0]) begin	// green
				errors++;
				$display("[ERROR] led_green: expected %02h, actual %02h",
					vram_writes[7:0], last_frame[23:16]);
			end
			if (last_frame[15:8] !== reg_writes[7:0]) begin	// red
				errors++;
				$display("[ERROR] led_red: expected %02h, actual %02h",
					reg_writes[7:0], last_frame[15:8]);
			end
			if (last_frame[7:0] !== status_reads[7:0]) begin	// blue
				errors++;
				$display("[ERROR] led_blue: expected %02h, actual %02h",
					status_reads[7:0], last_frame[7:0]);
			end
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	integer				fd;
	integer				got;
	logic [8*80-1:0]	line;

	initial begin
		rst = 1'b1;
		slot_iorq_n = 1'b1;
		slot_rd_n = 1'b1;
		slot_wr_n = 1'b1;
		slot_a = 8'h00;
		d_drive = 1'b0;
		d_out = 8'h00;
		seed = 79;
		checks = 0;
		errors = 0;
		timeouts = 0;
		abort = 1'b0;
		frames = 0;
		reg_writes = 0;
		vram_writes = 0;
		status_reads = 0;
		ptr_m = '0;
		ahead_m = 8'h00;
		ctrl_low_m = 8'h00;
		ctrl_second_m = 1'b0;
		for (int i = 0; i < (1 << vram_addr_w); i++)
			vram_m[i] = 8'h00;			// memory is cleared after reset
		repeat (16) @(posedge clk85m);
		#1;
		rst = 1'b0;
		next_cycle();
		checks++;
		if (slot_wait !== 1'b1) begin
			errors++;
			$display("[ERROR] reset_wait: expected 1, actual %b", slot_wait);
		end
		got = 0;
		while (slot_wait !== 1'b0 && got < (1 << vram_addr_w) + 64) begin	// VRAM clear
			next_cycle();
			got++;
		end
		if (slot_wait !== 1'b0) begin
			timeouts++;
			abort = 1'b1;
			$display("timeout: slot_wait did not fall after the VRAM clear");
		end
		fd = $fopen("verif/cartridge_tests.txt", "r");
		if (fd == 0) begin
			abort = 1'b1;
			$display("cannot open verif/cartridge_tests.txt");
		end
		while (!abort && !$feof(fd)) begin
			line = '0;
			got = $fgets(line, fd);
			if (got > 0)
				run_line(line);
		end
		if (fd != 0)
			$fclose(fd);
		if (!abort)
			check_led();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && !abort)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: hdl/vdp_cartridge_top.sv
// cartridge top level for the 8-bit I/O slot
// synchronizes the reset and connects slot bridge, port logic, video memory,
// activity monitor and LED serializer to the pins
`timescale 1ns/100ps

module vdp_cartridge_top import cartridge_pkg::*; (
	input	logic		clk85m,
	input	logic		rst,
	input	logic		slot_iorq_n,
	input	logic		slot_rd_n,
	input	logic		slot_wr_n,
	input	logic [7:0]	slot_a,
	inout	wire  [7:0]	slot_d,
	output	logic		slot_wait,
	output	logic		slot_intr,
	output	logic		slot_data_dir,
	output	logic		ws2812_led
);

	logic					rst_meta;
	logic					rst_sync;		// feeds every block
	logic					bus_valid, bus_write, bus_address, bus_ready, bus_rdata_en;
	logic [7:0]				bus_wdata, bus_rdata;
	logic					vram_valid, vram_write, vram_ready, vram_rdata_en;
	logic [vram_addr_w-1:0]	vram_address;
	logic [7:0]				vram_wdata, vram_rdata;
	logic					init_busy;
	logic					pulse_reg_write, pulse_vram_write, pulse_status_read;
	logic					led_wr, led_sending;
	logic [7:0]				led_red, led_green, led_blue;

	// ------------------------------
	// reset synchronizer
	// ------------------------------
	always_ff @(posedge clk85m) begin
		rst_meta <= rst;
		rst_sync <= rst_meta;
	end

	slot_bridge u_slot_bridge (
		.clk85m(clk85m), .rst(rst_sync),
		.slot_iorq_n(slot_iorq_n), .slot_rd_n(slot_rd_n), .slot_wr_n(slot_wr_n),
		.slot_a(slot_a), .slot_d(slot_d), .init_busy(init_busy),
		.slot_wait(slot_wait), .slot_data_dir(slot_data_dir),
		.bus_valid(bus_valid), .bus_write(bus_write), .bus_address(bus_address),
		.bus_wdata(bus_wdata), .bus_ready(bus_ready),
		.bus_rdata(bus_rdata), .bus_rdata_en(bus_rdata_en)
	);

	vdp_port u_vdp_port (
		.clk85m(clk85m), .rst(rst_sync),
		.bus_valid(bus_valid), .bus_write(bus_write), .bus_address(bus_address),
		.bus_wdata(bus_wdata), .bus_ready(bus_ready),
		.bus_rdata(bus_rdata), .bus_rdata_en(bus_rdata_en), .slot_intr(slot_intr),
		.vram_valid(vram_valid), .vram_write(vram_write), .vram_address(vram_address),
		.vram_wdata(vram_wdata), .vram_ready(vram_ready),
		.vram_rdata(vram_rdata), .vram_rdata_en(vram_rdata_en),
		.pulse_reg_write(pulse_reg_write), .pulse_vram_write(pulse_vram_write),
		.pulse_status_read(pulse_status_read)
	);

	vram_array u_vram_array (					// stands in for the SDRAM controller
		.clk85m(clk85m), .rst(rst_sync),
		.vram_valid(vram_valid), .vram_write(vram_write), .vram_address(vram_address),
		.vram_wdata(vram_wdata), .vram_ready(vram_ready),
		.vram_rdata(vram_rdata), .vram_rdata_en(vram_rdata_en), .init_busy(init_busy)
	);

	activity_monitor u_activity_monitor (
		.clk85m(clk85m), .rst(rst_sync),
		.pulse_reg_write(pulse_reg_write), .pulse_vram_write(pulse_vram_write),
		.pulse_status_read(pulse_status_read), .led_sending(led_sending),
		.led_wr(led_wr), .led_red(led_red), .led_green(led_green), .led_blue(led_blue)
	);

	led_serializer u_led_serializer (
		.clk85m(clk85m), .rst(rst_sync),
		.led_wr(led_wr), .led_red(led_red), .led_green(led_green), .led_blue(led_blue),
		.led_sending(led_sending), .led_out(ws2812_led)
	);

endmodule

// File: hdl/led_serializer.sv
// one-wire RGB LED serializer
// latches a colour on led_wr and sends 24 bits green, red, blue, MSB first,
// each bit a high pulse within a fixed symbol, followed by the latch gap
`timescale 1ns/100ps

module led_serializer import cartridge_pkg::*; (
	input	logic		clk85m,
	input	logic		rst,
	input	logic		led_wr,
	input	logic [7:0]	led_red,
	input	logic [7:0]	led_green,
	input	logic [7:0]	led_blue,
	output	logic		led_sending,
	output	logic		led_out
);

	typedef enum logic [1:0] {
		st_idle,
		st_bit,			// one symbol per bit
		st_gap			// line low for the latch
	} state_t;

	state_t					state;
	logic [led_bits-1:0]	shift;
	logic [led_cnt_w-1:0]	cnt;		// cycle within symbol or gap
	logic [4:0]				bit_idx;
	logic [led_cnt_w-1:0]	high_time;

	assign high_time = shift[led_bits-1] ? led_cnt_w'(led_t1h) : led_cnt_w'(led_t0h);

	always_ff @(posedge clk85m) begin
		if (rst) begin
			state       <= st_idle;
			cnt         <= '0;
			bit_idx     <= '0;
			led_sending <= 1'b0;
			led_out     <= 1'b0;
		end else begin
			led_out <= (state == st_bit) && (cnt < high_time);	// registered, no glitches
			case (state)
				st_idle: if (led_wr) begin
					shift       <= {led_green, led_red, led_blue};
					cnt         <= '0;
					bit_idx     <= '0;
					led_sending <= 1'b1;
					state       <= st_bit;
				end
				st_bit: begin
					if (cnt == led_cnt_w'(led_tbit - 1)) begin
						cnt   <= '0;
						shift <= shift << 1;	// next bit to MSB
						if (bit_idx == 5'(led_bits - 1))
							state <= st_gap;
						else
							bit_idx <= bit_idx + 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_gap: begin
					if (cnt == led_cnt_w'(led_treset - 1)) begin
						led_sending <= 1'b0;	// frame done
						state       <= st_idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: hdl/activity_monitor.sv
// activity monitor for the status LED
// counts register writes, VRAM writes and status reads into red, green and blue,
// and sends a fresh colour to the LED serializer whenever it is idle
`timescale 1ns/100ps

module activity_monitor import cartridge_pkg::*; (
	input	logic		clk85m,
	input	logic		rst,
	input	logic		pulse_reg_write,
	input	logic		pulse_vram_write,
	input	logic		pulse_status_read,
	input	logic		led_sending,
	output	logic		led_wr,
	output	logic [7:0]	led_red,
	output	logic [7:0]	led_green,
	output	logic [7:0]	led_blue
);

	logic [7:0]	cnt_red;		// register writes
	logic [7:0]	cnt_green;		// vram writes
	logic [7:0]	cnt_blue;		// status reads
	logic		dirty;			// counts differ from the last frame
	logic		any_event;
	logic		send;

	assign any_event = pulse_reg_write | pulse_vram_write | pulse_status_read;
	assign send      = dirty & ~led_sending & ~led_wr;	// sending rises a cycle after wr

	// ------------------------------
	// event counters
	// ------------------------------
	always_ff @(posedge clk85m) begin
		if (rst) begin
			cnt_red   <= '0;
			cnt_green <= '0;
			cnt_blue  <= '0;
			dirty     <= 1'b0;
			led_wr    <= 1'b0;
		end else begin
			cnt_red   <= cnt_red + pulse_reg_write;		// wraps at 8 bits
			cnt_green <= cnt_green + pulse_vram_write;
			cnt_blue  <= cnt_blue + pulse_status_read;
			led_wr    <= send;
			if (any_event)
				dirty <= 1'b1;			// keeps a change that races the send
			else if (send)
				dirty <= 1'b0;
		end
	end

	// colour bytes handed to the serializer with led_wr
	always_ff @(posedge clk85m) begin
		if (send) begin
			led_red   <= cnt_red;
			led_green <= cnt_green;
			led_blue  <= cnt_blue;
		end
	end

endmodule

// File: hdl/vram_array.sv
// byte-wide synchronous video memory
// clears every location after reset with init_busy high, then serves
// one access per cycle with one cycle of read latency
`timescale 1ns/100ps

module vram_array import cartridge_pkg::*; (
	input	logic					clk85m,
	input	logic					rst,
	input	logic					vram_valid,
	input	logic					vram_write,
	input	logic [vram_addr_w-1:0]	vram_address,
	input	logic [7:0]				vram_wdata,
	output	logic					vram_ready,
	output	logic [7:0]				vram_rdata,
	output	logic					vram_rdata_en,
	output	logic					init_busy
);

	logic [7:0]				mem [1 << vram_addr_w];
	logic [vram_addr_w-1:0]	clear_addr;
	logic					wr_en;
	logic [vram_addr_w-1:0]	wr_addr;
	logic [7:0]				wr_data;

	assign vram_ready = ~init_busy;
	assign wr_en      = init_busy | (vram_valid & vram_write);
	assign wr_addr    = init_busy ? clear_addr : vram_address;	// clear owns the port
	assign wr_data    = init_busy ? 8'h00 : vram_wdata;

	// ------------------------------
	// clear sequencer
	// ------------------------------
	always_ff @(posedge clk85m) begin
		if (rst) begin
			init_busy     <= 1'b1;
			clear_addr    <= '0;
			vram_rdata_en <= 1'b0;
		end else begin
			if (init_busy) begin
				clear_addr <= clear_addr + 1'b1;
				if (clear_addr == '1)		// last location written
					init_busy <= 1'b0;
			end
			vram_rdata_en <= vram_valid & ~vram_write & ~init_busy;
		end
	end

	// storage
	always_ff @(posedge clk85m) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		vram_rdata <= mem[vram_address];	// qualified by vram_rdata_en
	end

endmodule

// File: hdl/vdp_port.sv
// processor-port logic of the video processor
// data port with auto-increment and read-ahead, control port with two-byte latch,
// eight control registers, frame flag with interrupt, event pulses for the monitor
`timescale 1ns/100ps

module vdp_port import cartridge_pkg::*; (
	input	logic					clk85m,
	input	logic					rst,
	input	logic					bus_valid,
	input	logic					bus_write,
	input	logic					bus_address,
	input	logic [7:0]				bus_wdata,
	output	logic					bus_ready,
	output	logic [7:0]				bus_rdata,
	output	logic					bus_rdata_en,
	output	logic					slot_intr,
	output	logic					vram_valid,
	output	logic					vram_write,
	output	logic [vram_addr_w-1:0]	vram_address,
	output	logic [7:0]				vram_wdata,
	input	logic					vram_ready,
	input	logic [7:0]				vram_rdata,
	input	logic					vram_rdata_en,
	output	logic					pulse_reg_write,
	output	logic					pulse_vram_write,
	output	logic					pulse_status_read
);

	logic [7:0]				regs [reg_count];
	logic [vram_addr_w-1:0]	addr_ptr;		// auto-increment pointer
	logic [7:0]				ctrl_low;		// first control byte
	logic					ctrl_second;	// next control write is the second byte
	logic [7:0]				read_ahead;
	logic					fetch_wait;		// accepted read, data due next cycle
	logic					data_pending;	// vram request belongs to a bus access
	logic [frame_cnt_w-1:0]	frame_cnt;
	logic					frame_flag;
	logic					frame_tick;
	logic					vram_idle;

	assign frame_tick = (frame_cnt == frame_cycles - 1'b1);
	assign vram_idle  = ~vram_valid & ~fetch_wait;

	always_ff @(posedge clk85m) begin
		if (rst) begin
			bus_ready         <= 1'b0;
			bus_rdata_en      <= 1'b0;
			vram_valid        <= 1'b0;
			vram_write        <= 1'b0;
			addr_ptr          <= '0;
			ctrl_second       <= 1'b0;
			fetch_wait        <= 1'b0;
			data_pending      <= 1'b0;
			frame_cnt         <= '0;
			frame_flag        <= 1'b0;
			slot_intr         <= 1'b0;
			pulse_reg_write   <= 1'b0;
			pulse_vram_write  <= 1'b0;
			pulse_status_read <= 1'b0;
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else begin
			bus_ready         <= 1'b0;	// all single-cycle strobes
			bus_rdata_en      <= 1'b0;
			pulse_reg_write   <= 1'b0;
			pulse_vram_write  <= 1'b0;
			pulse_status_read <= 1'b0;

			// ------------------------------
			// frame timer and interrupt
			// ------------------------------
			frame_cnt <= frame_tick ? '0 : frame_cnt + 1'b1;
			slot_intr <= frame_flag & regs[reg_ie][ie_bit];

			// ------------------------------
			// vram completion
			// ------------------------------
			if (vram_rdata_en) begin
				read_ahead <= vram_rdata;
				fetch_wait <= 1'b0;
			end
			if (vram_valid && vram_ready) begin
				vram_valid <= 1'b0;
				fetch_wait <= ~vram_write;		// set wins over the clear above
				if (data_pending) begin
					data_pending     <= 1'b0;
					bus_ready        <= 1'b1;
					pulse_vram_write <= vram_write;
					bus_rdata        <= read_ahead;	// byte fetched earlier
					bus_rdata_en     <= ~vram_write;
				end
			end

			// ------------------------------
			// bus accesses
			// ------------------------------
			if (bus_valid && !bus_ready && !data_pending) begin
				if (bus_address == port_ctrl) begin
					bus_ready <= 1'b1;			// control port never waits
					if (bus_write) begin
						ctrl_second <= ~ctrl_second;
						if (!ctrl_second) begin
							ctrl_low <= bus_wdata;
						end else if (bus_wdata[7]) begin
							regs[bus_wdata[reg_idx_w-1:0]] <= ctrl_low;
							pulse_reg_write                <= 1'b1;
						end else if (!bus_wdata[6]) begin	// read address, prefetch
							vram_valid   <= 1'b1;
							vram_write   <= 1'b0;
							vram_address <= {bus_wdata[5:0], ctrl_low};
							addr_ptr     <= {bus_wdata[5:0], ctrl_low} + 1'b1;
						end else begin
							addr_ptr <= {bus_wdata[5:0], ctrl_low};	// write address
						end
					end else begin					// status read
						bus_rdata         <= {frame_flag, 7'd0};
						bus_rdata_en      <= 1'b1;
						ctrl_second       <= 1'b0;
						pulse_status_read <= 1'b1;
					end
				end else if (bus_address == port_data && vram_idle) begin
					vram_valid   <= 1'b1;
					vram_write   <= bus_write;		// read fetches the next byte
					vram_address <= addr_ptr;
					vram_wdata   <= bus_wdata;
					addr_ptr     <= addr_ptr + 1'b1;	// wraps at 14 bits
					data_pending <= 1'b1;
				end
			end

			// flag cleared by a status read, a new frame wins
			if (frame_tick)
				frame_flag <= 1'b1;
			else if (pulse_status_read)
				frame_flag <= 1'b0;
		end
	end

endmodule

// File: hdl/slot_bridge.sv
// slot I/O bridge between the asynchronous host strobes and the internal bus
// one bus transaction per decoded strobe, slot wait held until it completes
// read data is driven back onto the slot until rd_n is released
`timescale 1ns/100ps

module slot_bridge import cartridge_pkg::*; (
	input	logic		clk85m,
	input	logic		rst,
	input	logic		slot_iorq_n,
	input	logic		slot_rd_n,
	input	logic		slot_wr_n,
	input	logic [7:0]	slot_a,
	inout	wire  [7:0]	slot_d,
	input	logic		init_busy,
	output	logic		slot_wait,
	output	logic		slot_data_dir,
	output	logic		bus_valid,
	output	logic		bus_write,
	output	logic		bus_address,
	output	logic [7:0]	bus_wdata,
	input	logic		bus_ready,
	input	logic [7:0]	bus_rdata,
	input	logic		bus_rdata_en
);

	typedef enum logic [1:0] {
		st_idle,		// waiting for a strobe edge
		st_req,			// bus_valid held
		st_drive		// read data on the slot
	} state_t;

	state_t				state;
	logic [sync_stages-1:0]	iorq_sync;
	logic [sync_stages-1:0]	rd_sync;
	logic [sync_stages-1:0]	wr_sync;
	logic				acc_prev;		// access seen last cycle
	logic [7:0]			rd_data_q;		// byte returned to the host
	logic				iorq_s;
	logic				rd_s;
	logic				wr_s;
	logic				access_s;
	logic				decoded;
	logic				start;

	// ------------------------------
	// strobe synchronizers
	// ------------------------------
	always_ff @(posedge clk85m) begin
		if (rst) begin
			iorq_sync <= '1;			// all strobes idle high
			rd_sync   <= '1;
			wr_sync   <= '1;
			acc_prev  <= 1'b0;
		end else begin
			iorq_sync <= {iorq_sync[sync_stages-2:0], slot_iorq_n};
			rd_sync   <= {rd_sync[sync_stages-2:0], slot_rd_n};
			wr_sync   <= {wr_sync[sync_stages-2:0], slot_wr_n};
			acc_prev  <= access_s;
		end
	end

	assign iorq_s   = iorq_sync[sync_stages-1];
	assign rd_s     = rd_sync[sync_stages-1];
	assign wr_s     = wr_sync[sync_stages-1];
	assign access_s = ~iorq_s & (~rd_s | ~wr_s);
	assign decoded  = (slot_a[7:1] == io_base[7:1]);	// address stable during strobe
	assign start    = access_s & ~acc_prev & decoded & (state == st_idle);

	// ------------------------------
	// transaction FSM
	// ------------------------------
	always_ff @(posedge clk85m) begin
		if (rst) begin
			state         <= st_idle;
			bus_valid     <= 1'b0;
			slot_data_dir <= 1'b0;
		end else begin
			case (state)
				st_idle: if (start) begin
					bus_valid <= 1'b1;
					state     <= st_req;
				end
				st_req: if (bus_ready) begin	// bus_valid is high here
					bus_valid <= 1'b0;
					if (!bus_write) begin
						slot_data_dir <= 1'b1;	// turn the slot buffer around
						state         <= st_drive;
					end else begin
						state <= st_idle;
					end
				end
				st_drive: if (rd_s) begin	// host released rd_n
					slot_data_dir <= 1'b0;
					state         <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// request fields and read byte
	always_ff @(posedge clk85m) begin
		if (start) begin
			bus_write   <= ~wr_s;
			bus_address <= slot_a[0];
			bus_wdata   <= slot_d;			// host drives data with wr_n
		end
		if (bus_valid && bus_ready && bus_rdata_en)
			rd_data_q <= bus_rdata;
	end

	assign slot_wait = init_busy | bus_valid;	// host stalls during clear or a transaction
	assign slot_d    = slot_data_dir ? rd_data_q : 8'hzz;

endmodule

// File: hdl/cartridge_pkg.sv
// shared constants for the video-processor cartridge
// widths, slot port numbers, register indices, frame and LED timing
// imported by wildcard in every RTL module header
package cartridge_pkg;

	// ------------------------------
	// memory and slot decode
	// ------------------------------
	localparam int vram_addr_w = 14;				// 16 KiB video memory
	localparam logic [7:0] io_base = 8'h98;			// ports 98h-99h, bit 0 ignored
	localparam logic port_data = 1'b0;				// 98h
	localparam logic port_ctrl = 1'b1;				// 99h, control/status
	localparam int sync_stages = 2;					// strobe synchronizer depth

	// ------------------------------
	// control registers
	// ------------------------------
	localparam int reg_count = 8;
	localparam int reg_idx_w = $clog2(reg_count);
	localparam int reg_ie = 1;						// register holding interrupt enable
	localparam int ie_bit = 5;

	// ------------------------------
	// frame and LED timing
	// ------------------------------
	localparam int frame_cnt_w = 21;
	localparam logic [frame_cnt_w-1:0] frame_cycles = 21'd1431818;	// 60 Hz at 85.9 MHz
	localparam int led_bits = 24;					// green, red, blue
	localparam int led_cnt_w = 13;					// wide enough for the latch gap
	localparam int led_t0h = 34;					// high time of a zero
	localparam int led_t1h = 69;					// high time of a one
	localparam int led_tbit = 107;					// whole symbol
	localparam int led_treset = 4300;				// latch gap after a frame

endpackage
